// ==== fir_macros.svh ====
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// Width of one sample word, a sign bit plus a 15-bit magnitude
`define FIR_WIDTH 16

// Fractional bits of the fixed-point format
// A magnitude of 16384 stands for 1.0
`define FIR_FRAC 14

// Number of filter taps
`define FIR_TAPS 15

// Two's complement sum width
// 15 products below 1.0 each fit with room to spare
`define FIR_ACC_WIDTH 20

// Coefficient word, a sign bit plus a 16-bit magnitude
`define FIR_COEF_WIDTH 17

`endif

// ==== fir_pkg.sv ====
`include "fir_macros.svh"

package fir_pkg;

	// One sample word, read either whole or as sign and magnitude
	typedef union packed
	{
		logic [`FIR_WIDTH-1:0] raw; // Whole word, as the delay line and the ports carry it
		struct packed
		{
			logic                  sign; // 1 means negative
			logic [`FIR_WIDTH-2:0] mag;  // Magnitude with FIR_FRAC fractional bits
		} sm;
	} sample_u;

	// One coefficient word, with one more magnitude bit than a sample
	typedef union packed
	{
		logic [`FIR_COEF_WIDTH-1:0] raw;
		struct packed
		{
			logic                       sign;
			logic [`FIR_COEF_WIDTH-2:0] mag;
		} sm;
	} coef_u;

	// High-pass coefficient set, 15 taps, symmetric around tap 7
	// Signs alternate with even taps negative
	// The magnitudes add up to 7355, well below 1.0 (16384)
	localparam coef_u fir_coefs [`FIR_TAPS] = '{
		{1'b1, 16'd154}, // Tap 0
		{1'b0, 16'd218},
		{1'b1, 16'd339},
		{1'b0, 16'd472},
		{1'b1, 16'd601},
		{1'b0, 16'd709},
		{1'b1, 16'd781},
		{1'b0, 16'd807}, // Centre tap
		{1'b1, 16'd781},
		{1'b0, 16'd709},
		{1'b1, 16'd601},
		{1'b0, 16'd472},
		{1'b1, 16'd339},
		{1'b0, 16'd218},
		{1'b1, 16'd154}  // Tap 14
	};

endpackage

// ==== fir_delay_line.sv ====
`timescale 1ns/100ps
`include "fir_macros.svh"

// Sample window of the filter
// Entry 0 holds the newest sample and entry FIR_TAPS-1 the oldest
module fir_delay_line
(
	input  logic             clk,
	input  logic             arst_n,
	input  fir_pkg::sample_u x,               // New sample, taken on every rising edge
	output fir_pkg::sample_u taps [`FIR_TAPS] // Current window of samples
);

	// The whole window moves one place older on each edge
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `FIR_TAPS; i++)
			begin
				taps[i] <= '0; // An empty window filters to zero
			end
		end
		else
		begin
			for (int i = `FIR_TAPS - 1; i > 0; i--)
			begin
				taps[i] <= taps[i-1]; // Older samples shift down
			end
			taps[0].raw <= x.raw; // The sign bit travels along with the word
		end
	end

endmodule

// ==== fir_tap_mult.sv ====
`timescale 1ns/100ps
`include "fir_macros.svh"

// One tap of the filter
// Multiplies a sign-magnitude sample by a sign-magnitude coefficient in fixed point
// and hands the result on in two's complement, so the sum after it is exact
module fir_tap_mult
(
	input  fir_pkg::sample_u                   sample,  // Sample from the delay line
	input  fir_pkg::coef_u                     coef,    // Fixed coefficient of this tap
	output logic signed [`FIR_ACC_WIDTH-1:0]   product  // Product in two's complement
);

	import fir_pkg::*;

	// Top bit of the full magnitude product, 15 x 16 bits
	localparam int prod_top = `FIR_WIDTH + `FIR_COEF_WIDTH - 3;

	logic [prod_top:0]               mag_full; // Product before the fraction is dropped
	sample_u                         prod_sm;  // Product back in the sample format
	logic signed [`FIR_ACC_WIDTH-1:0] prod_ext; // Magnitude widened to the sum width

	assign mag_full = sample.sm.mag * coef.sm.mag; // Plain unsigned multiply of magnitudes

	always_comb
	begin
		// Shifting right by FIR_FRAC truncates toward zero
		prod_sm.sm.mag  = mag_full[`FIR_FRAC +: `FIR_WIDTH-1];
		// Signs differ gives a negative product, but a zero result stays positive
		prod_sm.sm.sign = (sample.sm.sign ^ coef.sm.sign) && (prod_sm.sm.mag != '0);
	end

	assign prod_ext = {{(`FIR_ACC_WIDTH - `FIR_WIDTH + 1){1'b0}}, prod_sm.sm.mag};

	assign product = prod_sm.sm.sign ? -prod_ext : prod_ext; // Negate for a negative product

	// Every coefficient is below 1.0, so the shifted product never needs more than the
	// 15 magnitude bits of a sample; the bits above that field must stay clear
	always_comb
	begin
		assert ((|mag_full[prod_top : `FIR_FRAC + `FIR_WIDTH - 1]) !== 1'b1)
		else
			$error("Tap product magnitude does not fit the sample magnitude field");
	end

endmodule

// ==== fir_adder.sv ====
`timescale 1ns/100ps
`include "fir_macros.svh"

// Summation stage
// Adds the tap products in a chain and registers the total one edge later
module fir_adder
(
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic signed [`FIR_ACC_WIDTH-1:0] products [`FIR_TAPS], // One product per tap
	output logic signed [`FIR_ACC_WIDTH-1:0] acc                   // Registered sum
);

	logic signed [`FIR_ACC_WIDTH-1:0] sum; // Combinational total of the current window

	// Tap 0 first, then each following tap added to the running total
	always_comb
	begin
		sum = products[0];
		for (int i = 1; i < `FIR_TAPS; i++)
		begin
			sum = sum + products[i]; // Width holds any sum of products below 1.0
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			acc <= '0;
		end
		else
		begin
			acc <= sum; // Window whose newest sample came in one edge earlier
		end
	end

	// The output word can only hold a magnitude below 1.0
	// This holds as long as the coefficient magnitudes stay below 1.0 in total
	a_acc_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		(acc < (1 << `FIR_FRAC)) && (acc > -(1 << `FIR_FRAC))
	)
	else
		$error("Filter sum %0d is out of the output range", acc);

endmodule

// ==== sm_out_convert.sv ====
`timescale 1ns/100ps
`include "fir_macros.svh"

// Output stage
// Turns the registered two's complement sum into a sign-magnitude word
module sm_out_convert
(
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic signed [`FIR_ACC_WIDTH-1:0] acc, // Sum from the adder
	output fir_pkg::sample_u                 y    // Filter output
);

	import fir_pkg::*;

	logic [`FIR_ACC_WIDTH-1:0] acc_abs; // Absolute value of the sum
	sample_u                   y_next;

	assign acc_abs = acc[`FIR_ACC_WIDTH-1] ? -acc : acc;

	always_comb
	begin
		y_next.sm.sign = acc[`FIR_ACC_WIDTH-1];  // A zero sum is not negative, so no -0
		y_next.sm.mag  = acc_abs[`FIR_WIDTH-2:0]; // Range of acc is checked in the adder
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			y <= '0;
		end
		else
		begin
			y <= y_next;
		end
	end

	// Negative zero must never reach the output
	a_no_neg_zero: assert property (
		@(posedge clk) disable iff (!arst_n)
		(y.sm.mag == '0) |-> !y.sm.sign
	)
	else
		$error("Output shows negative zero");

endmodule

// ==== fir_filter.sv ====
`timescale 1ns/100ps
`include "fir_macros.svh"

// 15-tap high-pass FIR filter on sign-magnitude samples
// One sample is taken per clock, and y follows with a latency of 2 clocks
module fir_filter
(
	input  logic             clk,
	input  logic             arst_n, // Asynchronous reset, active low
	input  fir_pkg::sample_u x,      // Input sample
	output fir_pkg::sample_u y       // Filtered output sample
);

	import fir_pkg::*;

	sample_u                          taps     [`FIR_TAPS]; // Sample window, newest first
	logic signed [`FIR_ACC_WIDTH-1:0] products [`FIR_TAPS]; // Per-tap products
	logic signed [`FIR_ACC_WIDTH-1:0] acc;                  // Registered sum

	fir_delay_line delay_line_i
	(
		.clk    (clk),
		.arst_n (arst_n),
		.x      (x),
		.taps   (taps)
	);

	// One multiplier per tap, each with its own fixed coefficient
	for (genvar i = 0; i < `FIR_TAPS; i++)
	begin : g_tap
		fir_tap_mult mult_i
		(
			.sample  (taps[i]),
			.coef    (fir_coefs[i]),
			.product (products[i])
		);
	end

	fir_adder adder_i
	(
		.clk      (clk),
		.arst_n   (arst_n),
		.products (products),
		.acc      (acc)
	);

	// Second pipeline register, back to the sign-magnitude format
	sm_out_convert convert_i
	(
		.clk    (clk),
		.arst_n (arst_n),
		.acc    (acc),
		.y      (y)
	);

endmodule

// ==== tb_fir_filter.sv ====
`timescale 1ns/100ps
`include "fir_macros.svh"

// Testbench for the 15-tap sign-magnitude FIR filter
module tb_fir_filter;

	import fir_pkg::*;

	localparam int n_random  = 300;                  // Random samples in the stream test
	localparam int n_cycles  = 129 + n_random;       // Clock cycles of all stimulus phases
	localparam int timeout_ns = (n_cycles + 100) * 10; // Whole run plus some margin
	localparam logic [`FIR_WIDTH-2:0] unit_mag = 15'd16384; // Magnitude of 1.0
	localparam int age_idle = 99;                    // Impulse age once nothing is tracked

	logic    clk;
	logic    arst_n;
	sample_u x;
	sample_u y;

	int      seed = 9; // Seed of the random stream
	int      model_errors = 0;
	int      impulse_errors = 0;
	int      reset_errors = 0;

	// Reference model state
	sample_u win [`FIR_TAPS]; // Own copy of the driven samples with the newest first
	int      model_acc;       // Exact sum of the products of win
	int      prod;
	int      exp_mid;         // Expected sum one clock later
	sample_u y_exp;           // Expected y two clocks after the sample

	// Impulse tracking for the isolated impulse tests
	logic    solo_on;  // Set while only isolated impulses are driven
	logic    imp_sign; // Sign of the last impulse
	int      imp_age;  // Edges since the last impulse was taken

	fir_filter fir_filter_i
	(
		.clk    (clk),
		.arst_n (arst_n),
		.x      (x),
		.y      (y)
	);

	always #5 clk = ~clk; // 10 ns period

	// Turns an exact sum into a sign-magnitude word where zero stays positive
	function automatic sample_u to_sample(input int v);
		sample_u w;
		int      a;
		a = (v < 0) ? -v : v;
		w.sm.sign = (v < 0);
		w.sm.mag  = a[`FIR_WIDTH-2:0];
		return w;
	endfunction

	// Output word for one tap of an impulse of magnitude 1.0
	function automatic sample_u coef_word(input int idx, input logic neg);
		sample_u w;
		w.sm.sign = fir_coefs[idx].sm.sign ^ neg; // A negative impulse flips each sign
		w.sm.mag  = fir_coefs[idx].sm.mag[`FIR_WIDTH-2:0];
		return w;
	endfunction

	// Products truncated toward zero, then added with their signs
	always_comb
	begin
		model_acc = 0;
		prod = 0;
		for (int i = 0; i < `FIR_TAPS; i++)
		begin
			prod = (int'(win[i].sm.mag) * int'(fir_coefs[i].sm.mag)) >> `FIR_FRAC;
			if (win[i].sm.sign != fir_coefs[i].sm.sign)
				model_acc = model_acc - prod; // A zero product adds nothing either way
			else
				model_acc = model_acc + prod;
		end
	end

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `FIR_TAPS; i++)
				win[i] <= '0;
			exp_mid <= 0;
			y_exp <= '0;
			imp_age <= age_idle;
			imp_sign <= 1'b0;
		end
		else
		begin
			for (int i = `FIR_TAPS - 1; i > 0; i--)
				win[i] <= win[i-1];
			win[0] <= x;
			exp_mid <= model_acc;        // Sum of the window taken one edge earlier
			y_exp <= to_sample(exp_mid); // Two edges after the sample
			if (solo_on && x.sm.mag == unit_mag)
			begin
				imp_age <= 0; // Impulse taken at this edge
				imp_sign <= x.sm.sign;
			end
			else if (imp_age < age_idle)
				imp_age <= imp_age + 1;
		end
	end

	// y must match the model in every cycle
	a_model: assert property (@(posedge clk) disable iff (!arst_n) y == y_exp)
	else
	begin
		model_errors++;
		$display("** Error @ %0t: y = %h, model expects %h", $time, y.raw, y_exp.raw);
	end

	// An isolated impulse of 1.0 shows the coefficients one after the other
	a_impulse: assert property (@(posedge clk) disable iff (!arst_n)
		(solo_on && imp_age >= 2 && imp_age < 2 + `FIR_TAPS)
		|-> (y == coef_word(imp_age - 2, imp_sign)))
	else
	begin
		impulse_errors++;
		$display("** Error @ %0t: impulse tap %0d gives y = %h", $time, imp_age - 2, y.raw);
	end

	// After the last tap the response has died out
	a_impulse_tail: assert property (@(posedge clk) disable iff (!arst_n)
		(solo_on && imp_age >= 2 + `FIR_TAPS && imp_age < age_idle) |-> (y.raw == '0))
	else
	begin
		impulse_errors++;
		$display("** Error @ %0t: y = %h after the impulse response ended", $time, y.raw);
	end

	a_reset: assert property (@(posedge clk) !arst_n |-> (y.raw == '0))
	else
	begin
		reset_errors++;
		$display("** Error @ %0t: y = %h during reset", $time, y.raw);
	end

	a_no_neg_zero: assert property (@(posedge clk) (y.sm.mag == '0) |-> !y.sm.sign)
	else
	begin
		model_errors++;
		$display("** Error @ %0t: y is negative zero", $time);
	end

	task automatic drive_sample(input sample_u s);
		@(negedge clk);
		x = s; // Taken at the next rising edge
	endtask

	task automatic drive_zeros(input int n, input logic neg);
		sample_u s;
		s.sm.sign = neg; // Negative zero must behave like zero
		s.sm.mag  = '0;
		repeat (n)
			drive_sample(s);
	endtask

	initial
	begin
		#(timeout_ns);
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		sample_u s;
		int      r;
		clk = 1'b0;
		arst_n = 1'b0;
		x = '0;
		solo_on = 1'b0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		drive_zeros(8, 1'b0); // Zero in, zero out

		// Isolated impulses of +1.0 and -1.0
		solo_on = 1'b1;
		s.sm.sign = 1'b0;
		s.sm.mag = unit_mag;
		drive_sample(s);
		drive_zeros(20, 1'b0);
		s.sm.sign = 1'b1;
		drive_sample(s);
		drive_zeros(20, 1'b1);
		@(negedge clk);
		solo_on = 1'b0; // Model checks alone from here on

		// Random stream with both signs and every eighth sample at full scale
		for (int i = 0; i < n_random; i++)
		begin
			r = $random(seed);
			s.raw = r[`FIR_WIDTH-1:0];
			if (i % 8 == 0)
				s.sm.mag = '1;
			drive_sample(s);
		end
		drive_zeros(20, 1'b0);

		// The responses of overlapping impulses must add up
		s.sm.sign = 1'b0;
		s.sm.mag = unit_mag;
		drive_sample(s);
		drive_zeros(4, 1'b0);
		s.sm.sign = 1'b1;
		s.sm.mag = 15'd8192; // Half scale, negative
		drive_sample(s);
		drive_zeros(3, 1'b0);
		s.sm.sign = 1'b0;
		s.sm.mag = unit_mag;
		drive_sample(s);
		drive_zeros(25, 1'b0);
		drive_zeros(20, 1'b0); // Drain the pipeline

		@(negedge clk);
		$display("Errors: %0d model, %0d impulse, %0d reset",
			model_errors, impulse_errors, reset_errors);
		if (model_errors + impulse_errors + reset_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
fir_pkg.sv
fir_delay_line.sv
fir_tap_mult.sv
fir_adder.sv
sm_out_convert.sv
fir_filter.sv
tb_fir_filter.sv

// ==== sim.sh ====
#!/bin/sh
# Build the FIR filter testbench with Verilator, run it and check the log
verilator --binary --timing --assert --top-module tb_fir_filter -f build.f -o tb_fir_filter \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_fir_filter > sim.log 2>&1 ; cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
